//--- design/adc_retime_pkg.sv
package adc_retime_pkg;

  // one adc conversion result
  localparam int sample_w = 24;

  // samples packed into one capture word
  localparam int lanes = 4;

  // full capture word, lane 0 in the low bits
  localparam int word_w = sample_w * lanes;

  // sample as it travels through the fifo
  // sync marks lane 0 of each capture word
  typedef struct packed {
    logic                sync;
    logic [sample_w-1:0] data;
  } adc_sample_t;

  // fifo status toward the read stage
  // overflow is a wr_clk pulse, underflow a rd_clk pulse
  typedef struct packed {
    logic empty;
    logic overflow;
    logic underflow;
  } adc_flags_t;

endpackage

//--- design/adc_stream_mux.sv
module adc_stream_mux (
  input  logic                               wr_clk,
  input  logic                               reset,
  input  logic [adc_retime_pkg::word_w-1:0]  din,
  input  logic                               dvld,
  output logic                               wr_reset,
  output adc_retime_pkg::adc_sample_t        sample,
  output logic                               sample_vld
);

  localparam int lane_w = $clog2(adc_retime_pkg::lanes);
  localparam logic [lane_w-1:0] last_lane = lane_w'(adc_retime_pkg::lanes - 1);

  // reset crossing into wr_clk
  logic reset_meta;

  // captured word and lane being presented
  logic [adc_retime_pkg::word_w-1:0] word_q;
  logic [lane_w-1:0]                 lane_q;
  logic                              busy_q;
  logic                              capture;

  // first output register straight from the lane select
  adc_retime_pkg::adc_sample_t       mux_q;
  logic                              mux_vld_q;

  // two-flop synchronizer for the reset level
  always_ff @(posedge wr_clk) begin
    reset_meta <= reset;
    wr_reset   <= reset_meta;
  end

  // new word accepted when idle or when the last lane goes out
  assign capture = dvld && (!busy_q || lane_q == last_lane);

  // control state of the serializer
  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      busy_q <= 1'b0;
      lane_q <= '0;
    end else if (capture) begin
      busy_q <= 1'b1;
      lane_q <= '0;
    end else if (busy_q) begin
      // idle again once lane 3 is out
      if (lane_q == last_lane) begin
        busy_q <= 1'b0;
      end
      lane_q <= lane_q + 1'b1;
    end
  end

  // word holding register
  always_ff @(posedge wr_clk) begin
    if (capture) begin
      word_q <= din;
    end
  end

  // lane select with sync only on lane 0
  always_ff @(posedge wr_clk) begin
    mux_q.data <= word_q[lane_q*adc_retime_pkg::sample_w +: adc_retime_pkg::sample_w];
    mux_q.sync <= (lane_q == '0);
  end

  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      mux_vld_q  <= 1'b0;
      sample_vld <= 1'b0;
    end else begin
      mux_vld_q  <= busy_q;
      // extra stage in front of the fifo write port
      sample_vld <= mux_vld_q;
    end
  end

  // payload of the extra stage
  always_ff @(posedge wr_clk) begin
    sample <= mux_q;
  end

endmodule

//--- design/adc_async_fifo.sv
module adc_async_fifo #(
  parameter type payload_t  = logic,
  parameter int  depth_log2 = 4
) (
  input  logic                        wr_clk,
  input  logic                        wr_reset,
  input  logic                        wr_en,
  input  payload_t                    wr_data,
  input  logic                        rd_clk,
  input  logic                        reset,
  input  logic                        rd_pop,
  output payload_t                    rd_data,
  output logic                        rd_valid,
  output adc_retime_pkg::adc_flags_t  flags
);

  // one extra pointer bit tells full from empty
  localparam int ptr_w = depth_log2 + 1;
  localparam int depth = 2 ** depth_log2;

  // gray xor pattern of a full fifo: top two bits differ, rest equal
  localparam logic [ptr_w-1:0] full_xor = {2'b11, {(depth_log2 - 1){1'b0}}};

  payload_t mem [depth];

  // write side pointers, wr_clk
  logic [ptr_w-1:0] wr_bin;
  logic [ptr_w-1:0] wr_bin_next;
  logic [ptr_w-1:0] wr_gray;
  logic [ptr_w-1:0] rd_gray_meta;
  logic [ptr_w-1:0] rd_gray_wsync;
  logic             full;
  logic             wr_ok;
  logic             overflow_q;

  // read side pointers, rd_clk
  logic [ptr_w-1:0] rd_bin;
  logic [ptr_w-1:0] rd_bin_next;
  logic [ptr_w-1:0] rd_gray;
  logic [ptr_w-1:0] wr_gray_meta;
  logic [ptr_w-1:0] wr_gray_rsync;
  logic             empty;
  logic             rd_ok;
  logic             underflow_q;

  // full against the synchronized read pointer, pessimistic while reads run
  assign full        = ((wr_gray ^ rd_gray_wsync) == full_xor);
  assign wr_ok       = wr_en && !full;
  assign wr_bin_next = wr_bin + 1'b1;

  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      overflow_q <= 1'b0;
    end else begin
      // dropped write flagged for one cycle
      overflow_q <= wr_en && full;
      if (wr_ok) begin
        wr_bin  <= wr_bin_next;
        wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
      end
    end
  end

  // read pointer into wr_clk
  always_ff @(posedge wr_clk) begin
    if (wr_reset) begin
      rd_gray_meta  <= '0;
      rd_gray_wsync <= '0;
    end else begin
      rd_gray_meta  <= rd_gray;
      rd_gray_wsync <= rd_gray_meta;
    end
  end

  // storage, written on wr_clk only
  always_ff @(posedge wr_clk) begin
    if (wr_ok) begin
      mem[wr_bin[depth_log2-1:0]] <= wr_data;
    end
  end

  // empty clears a few rd_clk cycles after the write, via the synchronizer
  assign empty       = (rd_gray == wr_gray_rsync);
  assign rd_ok       = rd_pop && !empty;
  assign rd_bin_next = rd_bin + 1'b1;

  always_ff @(posedge rd_clk) begin
    if (reset) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      rd_valid    <= 1'b0;
      underflow_q <= 1'b0;
    end else begin
      rd_valid    <= rd_ok;
      // pop on empty is dropped
      underflow_q <= rd_pop && empty;
      if (rd_ok) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
      end
    end
  end

  // write pointer into rd_clk
  always_ff @(posedge rd_clk) begin
    if (reset) begin
      wr_gray_meta  <= '0;
      wr_gray_rsync <= '0;
    end else begin
      wr_gray_meta  <= wr_gray;
      wr_gray_rsync <= wr_gray_meta;
    end
  end

  // read data lands with rd_valid
  always_ff @(posedge rd_clk) begin
    if (rd_ok) begin
      rd_data <= mem[rd_bin[depth_log2-1:0]];
    end
  end

  // overflow in wr_clk, the other two in rd_clk
  assign flags.empty     = empty;
  assign flags.overflow  = overflow_q;
  assign flags.underflow = underflow_q;

endmodule

//--- design/adc_read_stage.sv
module adc_read_stage (
  input  logic                                 rd_clk,
  input  logic                                 reset,
  input  logic                                 rd_en,
  input  adc_retime_pkg::adc_sample_t          rd_data,
  input  logic                                 rd_valid,
  input  adc_retime_pkg::adc_flags_t           flags,
  output logic                                 rd_pop,
  output logic [adc_retime_pkg::sample_w-1:0]  dout,
  output logic                                 dout_sync,
  output logic                                 dout_vld,
  output logic                                 fifo_empty,
  output logic                                 fifo_uf
);

  // control registers
  // empty comes up high so the reset state reads as empty
  always_ff @(posedge rd_clk) begin
    if (reset) begin
      rd_pop     <= 1'b0;
      dout_vld   <= 1'b0;
      fifo_empty <= 1'b1;
    end else begin
      // user request retimed into the pop
      rd_pop     <= rd_en;
      dout_vld   <= rd_valid;
      fifo_empty <= flags.empty;
    end
  end

  // dout holds the last sample between strobes
  always_ff @(posedge rd_clk) begin
    if (rd_valid) begin
      dout      <= rd_data.data;
      dout_sync <= rd_data.sync;
    end
  end

  // already a registered pulse inside the fifo
  assign fifo_uf = flags.underflow;

endmodule

//--- design/adc_retime.sv
module adc_retime #(
  parameter int depth_log2 = 4
) (
  // wr_clk domain
  input  logic                               wr_clk,
  input  logic [adc_retime_pkg::word_w-1:0]  din,
  input  logic                               dvld,
  output logic                               fifo_of,
  // rd_clk domain
  input  logic                               rd_clk,
  input  logic                               reset,
  input  logic                               rd_en,
  output logic [adc_retime_pkg::sample_w-1:0] dout,
  output logic                               dout_sync,
  output logic                               dout_vld,
  output logic                               fifo_empty,
  output logic                               fifo_uf
);

  // mux to fifo, wr_clk
  logic                         wr_reset;
  adc_retime_pkg::adc_sample_t  wr_sample;
  logic                         wr_sample_vld;

  // fifo to read stage, rd_clk
  adc_retime_pkg::adc_sample_t  rd_data;
  logic                         rd_valid;
  logic                         rd_pop;
  adc_retime_pkg::adc_flags_t   flags;

  adc_stream_mux u_mux (
    .wr_clk     (wr_clk),
    .reset      (reset),
    .din        (din),
    .dvld       (dvld),
    .wr_reset   (wr_reset),
    .sample     (wr_sample),
    .sample_vld (wr_sample_vld)
  );

  adc_async_fifo #(
    .payload_t  (adc_retime_pkg::adc_sample_t),
    .depth_log2 (depth_log2)
  ) u_fifo (
    .wr_clk   (wr_clk),
    .wr_reset (wr_reset),
    .wr_en    (wr_sample_vld),
    .wr_data  (wr_sample),
    .rd_clk   (rd_clk),
    .reset    (reset),
    .rd_pop   (rd_pop),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .flags    (flags)
  );

  adc_read_stage u_read (
    .rd_clk     (rd_clk),
    .reset      (reset),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .flags      (flags),
    .rd_pop     (rd_pop),
    .dout       (dout),
    .dout_sync  (dout_sync),
    .dout_vld   (dout_vld),
    .fifo_empty (fifo_empty),
    .fifo_uf    (fifo_uf)
  );

  // overflow stays in wr_clk
  assign fifo_of = flags.overflow;

endmodule

//--- tests/adc_retime_tb.sv
module adc_retime_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                                wr_clk;
  logic                                rd_clk;
  logic                                reset;
  logic [adc_retime_pkg::word_w-1:0]   din;
  logic                                dvld;
  logic                                rd_en;
  logic [adc_retime_pkg::sample_w-1:0] dout;
  logic                                dout_sync;
  logic                                dout_vld;
  logic                                fifo_empty;
  logic                                fifo_of;
  logic                                fifo_uf;

  // golden blocks, indexed by test
  string                             test_names [8];
  int                                word_first [8];
  int                                word_count [8];
  int                                exp_first [8];
  int                                exp_count [8];
  int                                n_tests;
  logic [adc_retime_pkg::word_w-1:0] words [$];
  // expected sample as {7'd0, sync, data}
  logic [31:0]                       expects [$];
  bit                                load_ok;
  bit                                load_done;

  // what the monitors saw
  logic [31:0] got [$];
  int          uf_count;
  int          of_count;

  int          err_count;
  int          errs_at_start;
  int          n_pass;
  int          n_fail;
  integer      seed;

  // 100 ns read clock, unrelated 70 ns write clock
  always #50 rd_clk = ~rd_clk;
  always #35 wr_clk = ~wr_clk;

  adc_retime #(
    .depth_log2 (4)
  ) DUT (
    .wr_clk     (wr_clk),
    .din        (din),
    .dvld       (dvld),
    .fifo_of    (fifo_of),
    .rd_clk     (rd_clk),
    .reset      (reset),
    .rd_en      (rd_en),
    .dout       (dout),
    .dout_sync  (dout_sync),
    .dout_vld   (dout_vld),
    .fifo_empty (fifo_empty),
    .fifo_uf    (fifo_uf)
  );

  // sampled mid-cycle, away from the clock edges
  always @(negedge rd_clk) begin
    if (!reset && dout_vld) begin
      got.push_back({7'd0, dout_sync, dout});
    end
    if (!reset && fifo_uf) begin
      uf_count++;
    end
  end

  // overflow lives in wr_clk
  always @(negedge wr_clk) begin
    if (fifo_of) begin
      of_count++;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s", msg);
    err_count++;
  endtask

  task automatic begin_test();
    errs_at_start = err_count;
    got.delete();
    uf_count = 0;
    of_count = 0;
  endtask

  task automatic end_test(input string name);
    if (err_count == errs_at_start) begin
      $display("test %s: ok", name);
      n_pass++;
    end else begin
      $display("test %s: %0d errors", name, err_count - errs_at_start);
      n_fail++;
    end
  endtask

  function automatic int find_test(input string name);
    int i;
    for (i = 0; i < n_tests; i++) begin
      if (test_names[i] == name) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic load_golden();
    int                                fd;
    int                                n;
    string                             line;
    string                             key;
    string                             name;
    logic [adc_retime_pkg::word_w-1:0] word;
    logic [23:0]                       data;
    int                                sync_bit;
    fd = $fopen("tests/adc_retime_golden.txt", "r");
    load_ok = (fd != 0);
    while (load_ok && !$feof(fd)) begin
      n = $fgets(line, fd);
      // comment lines yield key "#" and fall through
      if (n > 0 && $sscanf(line, "%s", key) == 1) begin
        if (key == "test" && n_tests < 8) begin
          n = $sscanf(line, "%s %s", key, name);
          test_names[n_tests] = name;
          word_first[n_tests] = words.size();
          exp_first[n_tests] = expects.size();
          n_tests++;
        end else if (key == "write" && n_tests > 0) begin
          n = $sscanf(line, "%s %h", key, word);
          words.push_back(word);
          word_count[n_tests-1]++;
        end else if (key == "expect" && n_tests > 0) begin
          n = $sscanf(line, "%s %h %d", key, data, sync_bit);
          expects.push_back({7'd0, sync_bit[0], data});
          exp_count[n_tests-1]++;
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    // all three golden blocks needed
    if (find_test("ordered_stream") < 0 || find_test("overflow") < 0 ||
        find_test("back_pressure") < 0) begin
      load_ok = 1'b0;
    end
  endtask

  // one strobe, then three idle cycles: one word per four wr_clk cycles
  task automatic write_word(input logic [adc_retime_pkg::word_w-1:0] word);
    @(posedge wr_clk);
    #5;
    din = word;
    dvld = 1'b1;
    @(posedge wr_clk);
    #5;
    dvld = 1'b0;
    repeat (2) @(posedge wr_clk);
  endtask

  task automatic write_block(input int t);
    int i;
    for (i = 0; i < word_count[t]; i++) begin
      write_word(words[word_first[t] + i]);
    end
    // last lanes still in the mux pipeline
    repeat (4) @(posedge wr_clk);
  endtask

  task automatic set_rd_en(input logic value);
    @(posedge rd_clk);
    #5;
    rd_en = value;
  endtask

  // wait for n samples with a bound, then a quiet window for extras
  task automatic collect(input int n);
    int cycles;
    cycles = 0;
    while (got.size() < n && cycles < n * 20 + 50) begin
      @(negedge rd_clk);
      cycles++;
    end
    repeat (8) @(negedge rd_clk);
  endtask

  task automatic random_reads(input int n);
    int     cycles;
    integer rnd;
    cycles = 0;
    while (got.size() < n && cycles < n * 40 + 100) begin
      @(posedge rd_clk);
      #5;
      rnd = $random(seed);
      rd_en = rnd[0];
      cycles++;
    end
    set_rd_en(1'b0);
  endtask

  task automatic compare_stream(input string name, input int t);
    int i;
    if (got.size() < exp_count[t]) begin
      report_error($sformatf("%s: %0d of %0d samples never arrived", name,
                             exp_count[t] - got.size(), exp_count[t]));
    end else if (got.size() > exp_count[t]) begin
      report_error($sformatf("%s: %0d samples more than expected", name,
                             got.size() - exp_count[t]));
    end
    for (i = 0; i < exp_count[t] && i < got.size(); i++) begin
      check_value(name, expects[exp_first[t] + i], got[i]);
    end
  endtask

  task automatic reset_state();
    begin_test();
    repeat (4) @(negedge rd_clk);
    check_value("reset_state", 32'd1, {31'd0, fifo_empty});
    check_value("reset_state", 32'd0, {31'd0, dout_vld});
    check_value("reset_state", 32'd0, {31'd0, fifo_of});
    check_value("reset_state", 32'd0, {31'd0, fifo_uf});
    end_test("reset_state");
  endtask

  task automatic ordered_stream();
    int t;
    t = find_test("ordered_stream");
    begin_test();
    set_rd_en(1'b1);
    write_block(t);
    collect(exp_count[t]);
    compare_stream("ordered_stream", t);
    set_rd_en(1'b0);
    end_test("ordered_stream");
  endtask

  task automatic underflow_pulse();
    // let the pops still in flight settle
    repeat (4) @(negedge rd_clk);
    begin_test();
    set_rd_en(1'b1);
    set_rd_en(1'b0);
    repeat (6) @(negedge rd_clk);
    check_value("underflow", 32'd1, (uf_count > 0) ? 32'd1 : 32'd0);
    check_value("underflow", 32'd0, got.size());
    end_test("underflow");
  endtask

  task automatic overflow_drain();
    int t;
    t = find_test("overflow");
    begin_test();
    // rd_en stays low, the fifo fills
    write_block(t);
    check_value("overflow", 32'd1, (of_count > 0) ? 32'd1 : 32'd0);
    set_rd_en(1'b1);
    collect(exp_count[t]);
    compare_stream("overflow", t);
    check_value("overflow", 32'd1, {31'd0, fifo_empty});
    set_rd_en(1'b0);
    end_test("overflow");
  endtask

  task automatic back_pressure();
    int t;
    t = find_test("back_pressure");
    repeat (4) @(negedge rd_clk);
    begin_test();
    fork
      write_block(t);
      random_reads(exp_count[t]);
    join
    repeat (8) @(negedge rd_clk);
    compare_stream("back_pressure", t);
    check_value("back_pressure", 32'd0, of_count);
    end_test("back_pressure");
  endtask

  // bound from the golden word count, 400 ns per word, margin 20
  initial begin : watchdog
    wait (load_done);
    if (load_ok) begin
      #(words.size() * 4 * 100 * 20);
      $display("timeout: tests still running at %0t", $time);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin : main
    wr_clk = 1'b0;
    rd_clk = 1'b0;
    reset = 1'b1;
    din = '0;
    dvld = 1'b0;
    rd_en = 1'b0;
    seed = 82;
    load_golden();
    load_done = 1'b1;
    if (!load_ok) begin
      $display("golden file tests/adc_retime_golden.txt missing or incomplete");
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      repeat (3) @(posedge rd_clk);
      #5;
      reset = 1'b0;
      reset_state();
      ordered_stream();
      underflow_pulse();
      overflow_drain();
      back_pressure();
      $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
      if (n_fail == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- adc_retime.f
design/adc_retime_pkg.sv
design/adc_stream_mux.sv
design/adc_async_fifo.sv
design/adc_read_stage.sv
design/adc_retime.sv
tests/adc_retime_tb.sv

//--- Makefile
# Verilator flow for the adc_retime subsystem
VERILATOR ?= verilator
FILELIST  ?= adc_retime.f
TOP       ?= adc_retime_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
SIM_BIN   ?= sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
	  echo "simulation reported errors, see $(LOG)"; \
	  exit 1; \
	elif ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "simulation ended without a verdict, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/adc_retime_golden.txt
# test <name> opens a block; write <capture word, 96-bit hex, lane 0 in bits 23:0>
# expect <sample, 24-bit hex> <sync bit>, listed in output order
test ordered_stream
write a5a5a58000007fffff000001
write 0f0f0ffedcbaabcdef123456
expect 000001 1
expect 7fffff 0
expect 800000 0
expect a5a5a5 0
expect 123456 1
expect abcdef 0
expect fedcba 0
expect 0f0f0f 0
test overflow
write 010003010002010001010000
write 020003020002020001020000
write 030003030002030001030000
write 040003040002040001040000
write 050003050002050001050000
write 060003060002060001060000
write 070003070002070001070000
write 080003080002080001080000
expect 010000 1
expect 010001 0
expect 010002 0
expect 010003 0
expect 020000 1
expect 020001 0
expect 020002 0
expect 020003 0
expect 030000 1
expect 030001 0
expect 030002 0
expect 030003 0
expect 040000 1
expect 040001 0
expect 040002 0
expect 040003 0
test back_pressure
write c0ffeedeadbe3c3c3c000fff
write 55aaff00ff11223344fedcb9
expect 000fff 1
expect 3c3c3c 0
expect deadbe 0
expect c0ffee 0
expect fedcb9 1
expect 223344 0
expect 00ff11 0
expect 55aaff 0
